// File: Bender.yml
package:
  name: cam_capture

sources:
  - include_dirs:
      - logic
    files:
      - logic/cam_capture_pkg.sv
      - logic/rstn_sync.sv
      - logic/cam_pixel_packer.sv
      - logic/async_word_fifo.sv
      - logic/cam_axi_burst_writer.sv
      - logic/cam_capture_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/tb_clock_gen.sv
      - verification/cam_axi_chk.sv
      - verification/cam_capture_tb.sv

// File: all.f
+incdir+logic
logic/cam_capture_pkg.sv
logic/rstn_sync.sv
logic/cam_pixel_packer.sv
logic/async_word_fifo.sv
logic/cam_axi_burst_writer.sv
logic/cam_capture_top.sv
verification/tb_clock_gen.sv
verification/cam_axi_chk.sv
verification/cam_capture_tb.sv

// File: logic/async_word_fifo.sv
`timescale 1ns/1ns
`include "cam_capture_config.svh"

module async_word_fifo import cam_capture_pkg::*; (
    input  logic      wclk,
    input  logic      wrstn,
    input  logic      wr_en,
    input  cam_word_u wr_word,
    input  logic      rclk,
    input  logic      rrstn,
    input  logic      rd_en,
    output cam_word_u rd_word,
    output logic      burst_ready
);

    localparam int DEPTH = `CAM_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    logic [31:0] mem [DEPTH];
    logic [AW:0] wbin;
    logic [AW:0] wbin_nxt;
    logic [AW:0] wgray;
    logic [AW:0] rbin;
    logic [AW:0] rbin_nxt;
    logic [AW:0] rgray;
    logic [AW:0] rgray_w1;
    logic [AW:0] rgray_w2;
    logic [AW:0] wgray_r1;
    logic [AW:0] wgray_r2;
    logic [AW:0] level;
    logic        full;
    logic        push;
    logic        pop;

    function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
        logic [AW:0] b;
        b[AW] = g[AW];
        for (int i = AW - 1; i >= 0; i--) begin
            b[i] = b[i + 1] ^ g[i];
        end
        return b;
    endfunction

    // write side
    assign wbin_nxt = wbin + 1'b1;
    assign full     = (wgray == {~rgray_w2[AW:AW-1], rgray_w2[AW-2:0]});
    assign push     = wr_en && !full; // dropped when full

    always_ff @(posedge wclk) begin
        if (push) begin
            mem[wbin[AW-1:0]] <= wr_word.raw;
        end
    end

    always_ff @(posedge wclk or negedge wrstn) begin
        if (!wrstn) begin
            wbin     <= '0;
            wgray    <= '0;
            rgray_w1 <= '0;
            rgray_w2 <= '0;
        end else begin
            rgray_w1 <= rgray;
            rgray_w2 <= rgray_w1;
            if (push) begin
                wbin  <= wbin_nxt;
                wgray <= wbin_nxt ^ (wbin_nxt >> 1);
            end
        end
    end

    // read side shows the head word without a read cycle
    assign rbin_nxt    = rbin + 1'b1;
    assign level       = gray2bin(wgray_r2) - rbin;
    assign pop         = rd_en && (level != '0);
    assign burst_ready = (level >= `CAM_BURST_BEATS);
    assign rd_word     = cam_word_u'(mem[rbin[AW-1:0]]);

    always_ff @(posedge rclk or negedge rrstn) begin
        if (!rrstn) begin
            rbin     <= '0;
            rgray    <= '0;
            wgray_r1 <= '0;
            wgray_r2 <= '0;
        end else begin
            wgray_r1 <= wgray;
            wgray_r2 <= wgray_r1;
            if (pop) begin
                rbin  <= rbin_nxt;
                rgray <= rbin_nxt ^ (rbin_nxt >> 1);
            end
        end
    end

endmodule

// File: logic/cam_axi_burst_writer.sv
`timescale 1ns/1ns
`include "cam_capture_config.svh"

module cam_axi_burst_writer import cam_capture_pkg::*; (
    input  logic         clk,
    input  logic         ov_rstn_sync,
    input  logic         capture_on,
    input  capture_cfg_t cfg,
    input  logic         burst_ready,
    input  cam_word_u    rd_word,
    output logic         rd_en,
    output axi_aw_t      aw,
    input  logic         awready,
    output axi_w_t       w,
    input  logic         wready,
    input  logic         bvalid,
    output logic         bready
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ADDR = 2'd1;
    localparam logic [1:0] ST_DATA = 2'd2;
    localparam logic [1:0] ST_RESP = 2'd3;

    localparam int BEAT_W = $clog2(`CAM_BURST_BEATS);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`CAM_BURST_BEATS - 1);
    localparam logic [`CAM_ADDR_W:0] STEP = (`CAM_ADDR_W + 1)'(4 * `CAM_BURST_BEATS);

    logic [1:0]             state;
    logic [1:0]             state_nxt;
    logic [BEAT_W-1:0]      beat;
    logic [`CAM_ADDR_W-1:0] ring_off; // offset from base
    logic [`CAM_ADDR_W:0]   off_nxt;
    logic                   aw_hs;
    logic                   w_hs;
    logic                   b_hs;

    assign aw_hs = aw.valid && awready;
    assign w_hs  = w.valid && wready;
    assign b_hs  = bvalid && bready;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: if (capture_on && burst_ready) state_nxt = ST_ADDR;
            ST_ADDR: if (aw_hs) state_nxt = ST_DATA;
            ST_DATA: if (w_hs && w.last) state_nxt = ST_RESP;
            default: if (b_hs) state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge ov_rstn_sync) begin
        if (!ov_rstn_sync) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk or negedge ov_rstn_sync) begin
        if (!ov_rstn_sync) begin
            beat <= '0;
        end else if (w_hs) begin
            beat <= w.last ? '0 : beat + 1'b1;
        end
    end

    // ring position wraps before base + num
    assign off_nxt = {1'b0, ring_off} + STEP;

    always_ff @(posedge clk or negedge ov_rstn_sync) begin
        if (!ov_rstn_sync) begin
            ring_off <= '0;
        end else if ((state == ST_IDLE) && !capture_on) begin
            ring_off <= '0;
        end else if (b_hs) begin
            if (off_nxt >= {1'b0, cfg.num_bytes}) begin
                ring_off <= '0;
            end else begin
                ring_off <= off_nxt[`CAM_ADDR_W-1:0];
            end
        end
    end

    assign aw.addr  = cfg.base_addr + ring_off;
    assign aw.valid = (state == ST_ADDR);
    assign w.data   = rd_word;
    assign w.last   = (beat == LAST_BEAT);
    assign w.valid  = (state == ST_DATA);
    assign bready   = (state == ST_RESP);
    assign rd_en    = w_hs; // pop only on a real transfer

endmodule

// File: logic/cam_capture_config.svh
`ifndef CAM_CAPTURE_CONFIG_SVH
`define CAM_CAPTURE_CONFIG_SVH

// 32-bit beats per AXI INCR burst
`define CAM_BURST_BEATS 16

// async FIFO depth in words must be a power of two
`define CAM_FIFO_DEPTH 64

`define CAM_ADDR_W 32

`endif

// File: logic/cam_capture_pkg.sv
`include "cam_capture_config.svh"

package cam_capture_pkg;

    // first camera byte lands in the upper half
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    typedef union packed {
        logic [31:0]   raw;
        rgb565_t [1:0] pix; // pix[0] is the earlier pixel
    } cam_word_u;

    typedef struct packed {
        logic       vsync;
        logic       href;
        logic [7:0] data;
    } cam_port_t;

    typedef struct packed {
        logic [`CAM_ADDR_W-1:0] addr;
        logic                   valid;
    } axi_aw_t;

    typedef struct packed {
        cam_word_u data;
        logic      last;
        logic      valid;
    } axi_w_t;

    typedef struct packed {
        logic [31:0] base_addr;
        logic [31:0] num_bytes;
        logic [15:0] width;
        logic [15:0] height;
    } capture_cfg_t;

endpackage

// File: logic/cam_capture_top.sv
`timescale 1ns/1ns

module cam_capture_top import cam_capture_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  logic         pclk,
    input  cam_port_t    cam,
    input  logic         cam_rstn,
    input  capture_cfg_t cfg,
    input  logic         capture_on,
    output axi_aw_t      aw,
    input  logic         awready,
    output axi_w_t       w,
    input  logic         wready,
    input  logic         bvalid,
    input  logic [1:0]   bresp,
    output logic         bready
);

    logic      ov_rstn_sync;
    logic      pclk_rstn;
    logic      wr_en;
    cam_word_u wr_word;
    logic      rd_en;
    cam_word_u rd_word;
    logic      burst_ready;

    rstn_sync u_rstn_clk (
        .clk      (clk),
        .rstn     (rstn),
        .rstn_out (ov_rstn_sync)
    );

    // camera side reset
    rstn_sync u_rstn_pclk (
        .clk      (pclk),
        .rstn     (cam_rstn),
        .rstn_out (pclk_rstn)
    );

    cam_pixel_packer u_packer (
        .pclk       (pclk),
        .pclk_rstn  (pclk_rstn),
        .cam        (cam),
        .capture_on (capture_on),
        .width      (cfg.width),
        .height     (cfg.height),
        .wr_en      (wr_en),
        .wr_word    (wr_word)
    );

    async_word_fifo u_fifo (
        .wclk        (pclk),
        .wrstn       (pclk_rstn),
        .wr_en       (wr_en),
        .wr_word     (wr_word),
        .rclk        (clk),
        .rrstn       (ov_rstn_sync),
        .rd_en       (rd_en),
        .rd_word     (rd_word),
        .burst_ready (burst_ready)
    );

    // bresp is taken in but the writer ignores it
    cam_axi_burst_writer u_writer (
        .clk          (clk),
        .ov_rstn_sync (ov_rstn_sync),
        .capture_on   (capture_on),
        .cfg          (cfg),
        .burst_ready  (burst_ready),
        .rd_word      (rd_word),
        .rd_en        (rd_en),
        .aw           (aw),
        .awready      (awready),
        .w            (w),
        .wready       (wready),
        .bvalid       (bvalid),
        .bready       (bready)
    );

endmodule

// File: logic/cam_pixel_packer.sv
`timescale 1ns/1ns

module cam_pixel_packer import cam_capture_pkg::*; (
    input  logic        pclk,
    input  logic        pclk_rstn,
    input  cam_port_t   cam,
    input  logic        capture_on,
    input  logic [15:0] width,
    input  logic [15:0] height,
    output logic        wr_en,
    output cam_word_u   wr_word
);

    logic [1:0]  cap_sync;
    logic        vsync_d;
    logic        href_d;
    logic        vsync_rise;
    logic        frame_en;
    logic [15:0] row;
    logic [16:0] col_byte; // byte column within the line
    logic        pix_sel;
    logic [7:0]  byte_hi;
    logic        keep;

    assign vsync_rise = cam.vsync && !vsync_d;

    // inside the crop window of an enabled frame
    assign keep = frame_en && cam.href && (row < height) && (col_byte[16:1] < width);

    always_ff @(posedge pclk or negedge pclk_rstn) begin
        if (!pclk_rstn) begin
            cap_sync <= 2'b00;
            vsync_d  <= 1'b0;
            href_d   <= 1'b0;
            frame_en <= 1'b0;
            row      <= '0;
            col_byte <= '0;
        end else begin
            cap_sync <= {cap_sync[0], capture_on};
            vsync_d  <= cam.vsync;
            href_d   <= cam.href;
            if (vsync_rise) begin
                frame_en <= cap_sync[1]; // capture decided once per frame
                row      <= '0;
                col_byte <= '0;
            end else if (cam.href) begin
                col_byte <= col_byte + 17'd1;
            end else if (href_d) begin
                row      <= row + 16'd1; // end of line
                col_byte <= '0;
            end
        end
    end

    always_ff @(posedge pclk or negedge pclk_rstn) begin
        if (!pclk_rstn) begin
            pix_sel <= 1'b0;
            wr_en   <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            if (vsync_rise) begin
                pix_sel <= 1'b0;
            end else if (keep && col_byte[0]) begin
                pix_sel <= ~pix_sel;
                wr_en   <= pix_sel; // second pixel closes the word
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (keep && !col_byte[0]) begin
            byte_hi <= cam.data;
        end
        if (keep && col_byte[0]) begin
            wr_word.pix[pix_sel] <= rgb565_t'({byte_hi, cam.data});
        end
    end

endmodule

// File: logic/rstn_sync.sv
`timescale 1ns/1ns

module rstn_sync (
    input  logic clk,
    input  logic rstn,
    output logic rstn_out
);

    logic [1:0] sync_q;

    // assert at once, release after two edges
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    assign rstn_out = sync_q[1];

endmodule

// File: verification/cam_axi_chk.sv
`timescale 1ns/1ns

module cam_axi_chk import cam_capture_pkg::*; (
    input logic    clk,
    input logic    ov_rstn_sync,
    input axi_aw_t aw,
    input logic    awready,
    input axi_w_t  w,
    input logic    wready,
    input logic    bvalid,
    input logic    bready
);

    logic last_done; // last beat sent with the response still open
    int   fail_count = 0;

    always_ff @(posedge clk or negedge ov_rstn_sync) begin
        if (!ov_rstn_sync) begin
            last_done <= 1'b0;
        end else if (w.valid && wready && w.last) begin
            last_done <= 1'b1;
        end else if (bvalid && bready) begin
            last_done <= 1'b0;
        end
    end

    aw_hold: assert property (@(posedge clk) disable iff (!ov_rstn_sync)
        aw.valid && !awready |=> aw.valid && $stable(aw.addr))
        else begin
            $error("aw dropped or changed before its handshake");
            fail_count++;
        end

    w_hold: assert property (@(posedge clk) disable iff (!ov_rstn_sync)
        w.valid && !wready |=> w.valid && $stable(w.data.raw) && $stable(w.last))
        else begin
            $error("w dropped or changed before its handshake");
            fail_count++;
        end

    b_after_last: assert property (@(posedge clk) disable iff (!ov_rstn_sync)
        bready |-> last_done)
        else begin
            $error("bready raised without a finished burst");
            fail_count++;
        end

endmodule

bind cam_capture_top cam_axi_chk u_axi_chk (
    .clk          (clk),
    .ov_rstn_sync (ov_rstn_sync),
    .aw           (aw),
    .awready      (awready),
    .w            (w),
    .wready       (wready),
    .bvalid       (bvalid),
    .bready       (bready)
);

// File: verification/cam_capture_tb.sv
`timescale 1ns/1ns
`include "cam_capture_config.svh"

module cam_capture_tb import cam_capture_pkg::*; ();

    localparam int BEATS     = `CAM_BURST_BEATS;
    localparam int ROW_EXTRA = 2; // sensor rows below the window
    localparam int COL_EXTRA = 3; // sensor pixels right of the window
    localparam int BLANK     = 3;

    logic         clk;
    logic         pclk;
    logic         rstn;
    logic         cam_rstn;
    cam_port_t    cam;
    capture_cfg_t cfg;
    logic         capture_on;
    axi_aw_t      aw;
    logic         awready;
    axi_w_t       w;
    logic         wready;
    logic         bvalid;
    logic [1:0]   bresp;
    logic         bready;

    string       case_name[$];
    int          case_w[$];
    int          case_h[$];
    logic [31:0] case_base[$];
    logic [31:0] case_num[$];
    int          case_frames[$];
    int          case_cap[$];
    int          case_stall[$];

    logic [31:0] mem [logic [31:0]]; // slave memory by byte address
    logic [31:0] ref_q[$];
    string       cur_name = "init";
    logic [31:0] pix_seed = 32'd90;
    logic [31:0] stall_seed = 32'd90;
    int          stall_pct = 0;
    logic [31:0] ring_off = '0;
    logic [31:0] burst_addr = '0;
    int          beat_idx = 0;
    int          aw_count = 0;
    int          bursts_done = 0;
    logic        b_pending = 1'b0;
    int          cycle_cnt = 0;
    int          cycle_limit = 2000;

    tb_clock_gen #(.HALF_PERIOD(10)) u_clk_gen (.clk(clk));
    tb_clock_gen #(.HALF_PERIOD(15)) u_pclk_gen (.clk(pclk));

    cam_capture_top UUT (
        .clk        (clk),
        .rstn       (rstn),
        .pclk       (pclk),
        .cam        (cam),
        .cam_rstn   (cam_rstn),
        .cfg        (cfg),
        .capture_on (capture_on),
        .aw         (aw),
        .awready    (awready),
        .w          (w),
        .wready     (wready),
        .bvalid     (bvalid),
        .bresp      (bresp),
        .bready     (bready)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // ring offset after one burst
    function automatic logic [31:0] next_offset(input logic [31:0] off, input logic [31:0] num);
        logic [32:0] n;
        n = {1'b0, off} + 33'(4 * BEATS);
        return (n >= {1'b0, num}) ? 32'd0 : n[31:0];
    endfunction

    function automatic int frame_bytes(input int width, input int height);
        return (height + ROW_EXTRA) * (2 * (width + COL_EXTRA) + 2 * BLANK) + 4;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic clk_tick();
        @(posedge clk);
        #2;
    endtask

    task automatic pclk_tick();
        @(posedge pclk);
        #2;
    endtask

    task automatic read_cases();
        int          fd;
        int          n;
        string       line;
        string       name;
        int          fields[5];
        logic [31:0] base;
        logic [31:0] num;
        fd = $fopen("verification/cam_cases.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verification/cam_cases.txt");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %d %d %h %h %d %d %d", name, fields[0], fields[1],
                            base, num, fields[2], fields[3], fields[4]);
                if (n != 8) begin
                    abort_run({"malformed line in the cases file: ", line});
                end
                case_name.push_back(name);
                case_w.push_back(fields[0]);
                case_h.push_back(fields[1]);
                case_base.push_back(base);
                case_num.push_back(num);
                case_frames.push_back(fields[2]);
                case_cap.push_back(fields[3]);
                case_stall.push_back(fields[4]);
                cycle_limit += 2 * fields[2] * frame_bytes(fields[0], fields[1]);
            end
        end
        $fclose(fd);
    endtask

    task automatic blank_bytes();
        repeat (BLANK) begin
            pclk_tick();
            cam.href = 1'b0;
            pix_seed = lcg_step(pix_seed);
            cam.data = pix_seed[15:8]; // noise outside href
        end
    endtask

    // drives one sensor frame larger than the window and queues the expected words
    task automatic drive_frame(input int width, input int height, input bit enabled);
        logic [15:0] pix;
        logic [15:0] first_pix;
        bit          second;
        second = 1'b0;
        first_pix = '0;
        pclk_tick();
        cam.vsync = 1'b1;
        repeat (3) pclk_tick();
        cam.vsync = 1'b0;
        for (int r = 0; r < height + ROW_EXTRA; r++) begin
            blank_bytes();
            for (int c = 0; c < width + COL_EXTRA; c++) begin
                pix_seed = lcg_step(pix_seed);
                pix = pix_seed[23:8];
                pclk_tick();
                cam.href = 1'b1;
                cam.data = pix[15:8]; // high byte first
                pclk_tick();
                cam.data = pix[7:0];
                if (enabled && r < height && c < width) begin
                    if (second) begin
                        ref_q.push_back({pix, first_pix}); // earlier pixel low
                    end
                    first_pix = pix;
                    second = !second;
                end
            end
            blank_bytes();
        end
    endtask

    task automatic check_frame(input logic [31:0] start_off);
        logic [31:0] exp_mem [logic [31:0]];
        logic [31:0] off;
        off = start_off;
        for (int k = 0; k < ref_q.size(); k++) begin
            if (k > 0 && k % BEATS == 0) begin
                off = next_offset(off, cfg.num_bytes);
            end
            exp_mem[cfg.base_addr + off + 32'(4 * (k % BEATS))] = ref_q[k];
        end
        check_eq({cur_name, " words stored"}, exp_mem.num(), mem.num());
        foreach (exp_mem[a]) begin
            if (!mem.exists(a)) begin
                abort_run($sformatf("%s: nothing written at address %h", cur_name, a));
            end
            check_eq($sformatf("%s data @%h", cur_name, a), exp_mem[a], mem[a]);
        end
    endtask

    task automatic run_case(input int i);
        logic [31:0] frame_off;
        cur_name = case_name[i];
        clk_tick();
        capture_on = 1'b0;
        cfg.base_addr = case_base[i];
        cfg.num_bytes = case_num[i];
        cfg.width = 16'(case_w[i]);
        cfg.height = 16'(case_h[i]);
        stall_pct = case_stall[i];
        ring_off = '0; // writer reloads its base while capture is off
        repeat (10) clk_tick();
        for (int f = 0; f < case_frames[i]; f++) begin
            capture_on = (case_cap[i] != 0);
            repeat (8) clk_tick();
            mem.delete();
            ref_q.delete();
            aw_count = 0;
            bursts_done = 0;
            frame_off = ring_off;
            drive_frame(case_w[i], case_h[i], case_cap[i] != 0);
            if (case_cap[i] != 0) begin
                while (bursts_done < ref_q.size() / BEATS) begin
                    @(posedge clk);
                end
                repeat (2) clk_tick();
                check_frame(frame_off);
            end else begin
                repeat (100) clk_tick();
                check_eq({cur_name, " aw count"}, 0, aw_count);
            end
        end
    endtask

    // AXI slave checks addresses and beats and stores data with random stalls
    always @(posedge clk) begin
        if (aw.valid && awready) begin
            check_eq({cur_name, " burst addr"}, cfg.base_addr + ring_off, aw.addr);
            burst_addr = aw.addr;
            beat_idx = 0;
            aw_count++;
            ring_off = next_offset(ring_off, cfg.num_bytes);
        end
        if (w.valid && wready) begin
            check_eq({cur_name, " w.last"}, 32'(beat_idx == BEATS - 1), 32'(w.last));
            mem[burst_addr + 32'(4 * beat_idx)] = w.data.raw;
            beat_idx++;
            if (w.last) begin
                b_pending = 1'b1;
            end
        end
        if (bvalid && bready) begin
            b_pending = 1'b0;
            bursts_done++;
        end
        #2;
        stall_seed = lcg_step(stall_seed);
        awready = (int'(stall_seed[30:16]) % 100) >= stall_pct;
        stall_seed = lcg_step(stall_seed);
        wready = (int'(stall_seed[30:16]) % 100) >= stall_pct;
        bvalid = b_pending;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            abort_run($sformatf("timeout: run did not finish within %0d clk cycles",
                                cycle_limit));
        end
        if (UUT.u_axi_chk.fail_count != 0) begin
            abort_run("an AXI protocol assertion failed");
        end
    end

    initial begin
        rstn = 1'b0;
        cam_rstn = 1'b0;
        cam = '0;
        cfg = '0;
        capture_on = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        bresp = 2'b00;
        read_cases();
        repeat (2) @(posedge clk);
        #2;
        rstn = 1'b1;
        cam_rstn = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_eq("reset aw.valid", 0, 32'(aw.valid));
        check_eq("reset w.valid", 0, 32'(w.valid));
        check_eq("reset bready", 0, 32'(bready));
        for (int i = 0; i < case_name.size(); i++) begin
            run_case(i);
        end
        if (UUT.u_axi_chk.fail_count != 0) begin
            abort_run("an AXI protocol assertion failed");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// File: verification/cam_cases.txt
# name width height base_addr num_bytes frames capture stall_pct
# base_addr and num_bytes in hex, the other columns decimal
crop_small 8 4 00001000 00001000 2 1 0
ring_wrap 16 8 00002000 000000c0 2 1 0
gated 8 4 00003000 00001000 1 0 0
after_gate 8 4 00003000 00001000 1 1 0
stall_mid 16 4 00004000 00001000 2 1 30
stall_wrap 32 4 00005000 00000100 1 1 20

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int HALF_PERIOD = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule
